// ==== rtl/extMemPkg.sv ====
package extMemPkg;

    // sizing
    localparam int maxBurst = 8;
    localparam int memAddrBits = 10;

    // host register indices
    localparam logic [3:0] regCtrl = 4'd0;
    localparam logic [3:0] regAddr = 4'd1;
    localparam logic [3:0] regLen = 4'd2;
    localparam logic [3:0] regStatus = 4'd3;
    localparam logic [3:0] regWindow = 4'd8;

    // command word bits
    localparam int cmdWriteBit = 31;
    localparam int cmdMemBit = 29;

    typedef enum logic [1:0] {opWrite, opMemRead, opMmioRead} busOp;

    typedef enum logic [1:0] {stIdle, stCommand, stData, stFinish} masterState;

    typedef enum logic [1:0] {msLookup, msWrite, msRead} memState;

    typedef struct packed {
        busOp op;
        logic [29:0] addr;
        logic [3:0] len;
    } burstReq;

    typedef struct packed {
        logic wr;
        logic [3:0] addr;
        logic [31:0] data;
    } regAccess;

    typedef struct packed {
        logic we;
        logic [2:0] idx;
        logic [31:0] data;
    } windowWrite;

endpackage

// ==== rtl/ExternalMemory.sv ====
`timescale 1ns/10ps

module ExternalMemory (
    input  logic        clk,
    input  logic        arstN,
    input  logic        en,
    input  logic [31:0] busIn,
    output logic [31:0] memBus,
    output logic        memOen,
    output logic        memStall
);

    logic [31:0] mem [0:(1 << extMemPkg::memAddrBits) - 1];
    logic [extMemPkg::memAddrBits-1:0] addr;
    logic [31:0] rdData;
    logic [31:0] mmioCount;
    extMemPkg::memState state;

    logic cmdCycle;
    logic writeCmd;
    logic memReadCmd;
    logic mmioCmd;

    // command decode, only meaningful in the lookup state
    assign cmdCycle = en && state == extMemPkg::msLookup;
    assign writeCmd = cmdCycle && busIn[extMemPkg::cmdWriteBit];
    assign memReadCmd = cmdCycle && !busIn[extMemPkg::cmdWriteBit] && busIn[extMemPkg::cmdMemBit];
    assign mmioCmd = cmdCycle && !busIn[extMemPkg::cmdWriteBit] && !busIn[extMemPkg::cmdMemBit];

    assign memBus = rdData;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= extMemPkg::msLookup;
            memOen <= 1'b0;
            memStall <= 1'b0;
            mmioCount <= '0;
        end else begin
            // one stall cycle before the first read word
            memStall <= memReadCmd;
            memOen <= mmioCmd || (en && state == extMemPkg::msRead);
            if (mmioCmd) begin
                mmioCount <= mmioCount + 32'd1;
            end
            case (state)
                extMemPkg::msLookup: begin
                    if (writeCmd) begin
                        state <= extMemPkg::msWrite;
                    end else if (memReadCmd) begin
                        state <= extMemPkg::msRead;
                    end
                end
                extMemPkg::msWrite: begin
                    if (!en) begin
                        state <= extMemPkg::msLookup;
                    end
                end
                extMemPkg::msRead: begin
                    if (!en) begin
                        state <= extMemPkg::msLookup;
                    end
                end
                default: state <= extMemPkg::msLookup;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (en && state == extMemPkg::msWrite) begin
            mem[addr] <= busIn;
        end
    end

    // address wraps modulo memory size
    always_ff @(posedge clk) begin
        if (cmdCycle) begin
            addr <= busIn[extMemPkg::memAddrBits-1:0];
        end else if (en && state != extMemPkg::msLookup) begin
            addr <= addr + 1'b1;
        end
        if (mmioCmd) begin
            rdData <= mmioCount;
        end else if (en && state == extMemPkg::msRead) begin
            rdData <= mem[addr];
        end
    end

    stallAfterLookup: assert property (@(posedge clk) disable iff (!arstN)
        memStall |-> $past(en && state == extMemPkg::msLookup)
            && state == extMemPkg::msRead && !memOen)
        else $error("memStall outside the first cycle of a memory read");

endmodule

// ==== rtl/BusMaster.sv ====
`timescale 1ns/10ps

module BusMaster (
    input  logic                  clk,
    input  logic                  arstN,
    input  extMemPkg::burstReq    req,
    input  logic                  reqValid,
    output logic [2:0]            winIdx,
    input  logic [31:0]           winData,
    output extMemPkg::windowWrite winWr,
    output logic                  burstDone,
    output logic                  en,
    output logic [31:0]           busOut,
    input  logic [31:0]           memBus,
    input  logic                  memOen,
    input  logic                  memStall
);

    extMemPkg::masterState state;
    extMemPkg::burstReq reqReg;
    logic [2:0] dataCount;
    logic [3:0] capCount;
    logic [3:0] lenEff;
    logic [31:0] cmdWord;
    logic lastData;
    logic capture;
    logic lastCapture;

    // MMIO reads always move a single word
    assign lenEff = (reqReg.op == extMemPkg::opMmioRead) ? 4'd1 : reqReg.len;

    always_comb begin
        cmdWord = {2'b00, reqReg.addr};
        // address bits 29 and up never reach the bus
        cmdWord[extMemPkg::cmdWriteBit] = reqReg.op == extMemPkg::opWrite;
        cmdWord[extMemPkg::cmdMemBit] = reqReg.op != extMemPkg::opMmioRead;
    end

    assign lastData = {1'b0, dataCount} == reqReg.len - 4'd1;
    assign capture = memOen && capCount < lenEff;
    assign lastCapture = capture && capCount == lenEff - 4'd1;

    assign en = state == extMemPkg::stCommand || state == extMemPkg::stData;
    assign busOut = (state == extMemPkg::stCommand) ? cmdWord : winData;
    assign winIdx = dataCount;

    assign winWr.we = capture;
    assign winWr.idx = capCount[2:0];
    assign winWr.data = memBus;

    always_ff @(posedge clk) begin
        if (state == extMemPkg::stIdle && reqValid) begin
            reqReg <= req;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= extMemPkg::stIdle;
            dataCount <= '0;
            capCount <= '0;
            burstDone <= 1'b0;
        end else begin
            burstDone <= 1'b0;
            case (state)
                extMemPkg::stIdle: begin
                    if (reqValid) begin
                        state <= extMemPkg::stCommand;
                        dataCount <= '0;
                        capCount <= '0;
                    end
                end
                extMemPkg::stCommand: begin
                    state <= (reqReg.op == extMemPkg::opMmioRead) ?
                        extMemPkg::stFinish : extMemPkg::stData;
                end
                extMemPkg::stData: begin
                    dataCount <= dataCount + 3'd1;
                    if (lastData) begin
                        state <= extMemPkg::stFinish;
                        if (reqReg.op == extMemPkg::opWrite) begin
                            burstDone <= 1'b1;
                        end
                    end
                end
                extMemPkg::stFinish: begin
                    // reads wait here for the trailing word
                    if (reqReg.op == extMemPkg::opWrite || lastCapture) begin
                        state <= extMemPkg::stIdle;
                    end
                end
                default: state <= extMemPkg::stIdle;
            endcase
            if (capture) begin
                capCount <= capCount + 4'd1;
                if (lastCapture) begin
                    burstDone <= 1'b1;
                end
            end
        end
    end

    reqOnlyWhenIdle: assert property (@(posedge clk) disable iff (!arstN)
        reqValid |-> state == extMemPkg::stIdle)
        else $error("request arrived while a burst was running");

    noOenWhenIdle: assert property (@(posedge clk) disable iff (!arstN)
        state == extMemPkg::stIdle |-> !memOen)
        else $error("memory drove data while the master was idle");

    stallInReadData: assert property (@(posedge clk) disable iff (!arstN)
        memStall |-> state == extMemPkg::stData && reqReg.op == extMemPkg::opMemRead)
        else $error("stall outside the first data cycle of a read");

endmodule

// ==== rtl/ControlRegs.sv ====
`timescale 1ns/10ps

module ControlRegs (
    input  logic                  clk,
    input  logic                  arstN,
    input  extMemPkg::regAccess   hostAccess,
    output logic [31:0]           regRdata,
    output extMemPkg::burstReq    req,
    output logic                  reqValid,
    input  logic [2:0]            winIdx,
    output logic [31:0]           winData,
    input  extMemPkg::windowWrite winWr,
    input  logic                  burstDone,
    output logic                  busy,
    output logic                  done
);

    logic [31:0] ctrlReg;
    logic [29:0] addrReg;
    logic [3:0] lenReg;
    logic [31:0] window [0:extMemPkg::maxBurst-1];
    logic ctrlWrite;
    logic winHostWrite;

    function automatic logic [3:0] clampLen(logic [31:0] value);
        if (value == 32'd0) begin
            return 4'd1;
        end
        if (value > 32'(extMemPkg::maxBurst)) begin
            return 4'(extMemPkg::maxBurst);
        end
        return value[3:0];
    endfunction

    assign ctrlWrite = hostAccess.wr && hostAccess.addr == extMemPkg::regCtrl;
    assign winHostWrite = hostAccess.wr && hostAccess.addr >= extMemPkg::regWindow;

    // op code 3 behaves as an MMIO read
    assign req.op = (ctrlReg[1:0] == 2'd3) ? extMemPkg::opMmioRead :
        extMemPkg::busOp'(ctrlReg[1:0]);
    assign req.addr = addrReg;
    assign req.len = lenReg;

    assign winData = window[winIdx];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ctrlReg <= '0;
            addrReg <= '0;
            lenReg <= 4'd1;
            busy <= 1'b0;
            done <= 1'b0;
            reqValid <= 1'b0;
        end else begin
            reqValid <= 1'b0;
            if (ctrlWrite && !busy) begin
                ctrlReg <= hostAccess.data;
                busy <= 1'b1;
                done <= 1'b0;
                reqValid <= 1'b1;
            end else if (burstDone) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (hostAccess.wr && hostAccess.addr == extMemPkg::regAddr) begin
                addrReg <= hostAccess.data[29:0];
            end
            if (hostAccess.wr && hostAccess.addr == extMemPkg::regLen) begin
                lenReg <= clampLen(hostAccess.data);
            end
        end
    end

    // master write lands last so it wins a collision
    always_ff @(posedge clk) begin
        if (winHostWrite) begin
            window[hostAccess.addr[2:0]] <= hostAccess.data;
        end
        if (winWr.we) begin
            window[winWr.idx] <= winWr.data;
        end
    end

    always_comb begin
        regRdata = '0;
        if (hostAccess.addr >= extMemPkg::regWindow) begin
            regRdata = window[hostAccess.addr[2:0]];
        end else begin
            case (hostAccess.addr)
                extMemPkg::regCtrl: regRdata = ctrlReg;
                extMemPkg::regAddr: regRdata = {2'b00, addrReg};
                extMemPkg::regLen: regRdata = {28'd0, lenReg};
                extMemPkg::regStatus: regRdata = {30'd0, done, busy};
                default: regRdata = '0;
            endcase
        end
    end

    busyAfterReq: assert property (@(posedge clk) disable iff (!arstN)
        reqValid |=> busy)
        else $error("busy dropped right after a request");

endmodule

// ==== rtl/ExtMemSubsystem.sv ====
`timescale 1ns/10ps

module ExtMemSubsystem (
    input  logic                clk,
    input  logic                arstN,
    input  extMemPkg::regAccess hostAccess,
    output logic [31:0]         regRdata,
    output logic                busy,
    output logic                done
);

    extMemPkg::burstReq req;
    extMemPkg::windowWrite winWr;
    logic reqValid;
    logic [2:0] winIdx;
    logic [31:0] winData;
    logic burstDone;

    // shared external bus
    logic en;
    logic [31:0] busOut;
    logic [31:0] memBus;
    logic memOen;
    logic memStall;

    ControlRegs regs (
        .clk(clk),
        .arstN(arstN),
        .hostAccess(hostAccess),
        .regRdata(regRdata),
        .req(req),
        .reqValid(reqValid),
        .winIdx(winIdx),
        .winData(winData),
        .winWr(winWr),
        .burstDone(burstDone),
        .busy(busy),
        .done(done)
    );

    BusMaster master (
        .clk(clk),
        .arstN(arstN),
        .req(req),
        .reqValid(reqValid),
        .winIdx(winIdx),
        .winData(winData),
        .winWr(winWr),
        .burstDone(burstDone),
        .en(en),
        .busOut(busOut),
        .memBus(memBus),
        .memOen(memOen),
        .memStall(memStall)
    );

    ExternalMemory memory (
        .clk(clk),
        .arstN(arstN),
        .en(en),
        .busIn(busOut),
        .memBus(memBus),
        .memOen(memOen),
        .memStall(memStall)
    );

endmodule

// ==== tests/tbChecks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// reference memory, with a flag for words the testbench has written
logic [31:0] refMem [0:1023];
bit refKnown [0:1023];
logic [31:0] mmioCount = '0;

// expected window contents
logic [31:0] winModel [0:7];
bit winKnown [0:7];

int errors = 0;
int checks = 0;

function automatic logic [31:0] expectedWord(extMemPkg::busOp op, logic [29:0] addr,
        int index);
    logic [9:0] wordAddr;
    wordAddr = addr[9:0] + 10'(index);
    if (op == extMemPkg::opMmioRead) begin
        return mmioCount;
    end
    return refMem[wordAddr];
endfunction

// model side effects of one finished burst
function automatic void applyBurst(extMemPkg::busOp op, logic [29:0] addr, int len);
    logic [9:0] wordAddr;
    if (op == extMemPkg::opWrite) begin
        for (int i = 0; i < len; i++) begin
            wordAddr = addr[9:0] + 10'(i);
            refMem[wordAddr] = winModel[i];
            refKnown[wordAddr] = winKnown[i];
        end
    end else if (op == extMemPkg::opMemRead) begin
        for (int i = 0; i < len; i++) begin
            wordAddr = addr[9:0] + 10'(i);
            winModel[i] = expectedWord(op, addr, i);
            winKnown[i] = refKnown[wordAddr];
        end
    end else begin
        // one word, whatever the length
        winModel[0] = expectedWord(op, addr, 0);
        winKnown[0] = 1'b1;
        mmioCount = mmioCount + 32'd1;
    end
endfunction

task automatic checkWord(string name, logic [31:0] got, logic [31:0] want);
    checks++;
    if (got !== want) begin
        errors++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want);
    end
endtask

task automatic checkStatus(logic gotBusy, logic gotDone, logic wantBusy, logic wantDone);
    checks++;
    if ({gotBusy, gotDone} !== {wantBusy, wantDone}) begin
        errors++;
        $display("MISMATCH at %0t: busy/done got %b/%b expected %b/%b", $time,
            gotBusy, gotDone, wantBusy, wantDone);
    end
endtask

`endif

// ==== tests/tbExtMem.sv ====
`timescale 1ns/10ps

module tbExtMem;

    localparam int randomBursts = 40;
    // about 50 bursts of under 40 cycles each with host traffic, doubled
    localparam int cycleLimit = (randomBursts + 10) * 40 * 2;

    logic clk = 1'b0;
    logic arstN;
    extMemPkg::regAccess hostAccess;
    logic [31:0] regRdata;
    logic busy;
    logic done;
    int cycles = 0;
    int doneRises = 0;
    logic donePrev = 1'b0;

    `include "tbChecks.svh"

    ExtMemSubsystem dut (
        .clk(clk),
        .arstN(arstN),
        .hostAccess(hostAccess),
        .regRdata(regRdata),
        .busy(busy),
        .done(done)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        donePrev <= done;
        if (done && !donePrev) begin
            doneRises <= doneRises + 1;
        end
        if (cycles >= cycleLimit) begin
            $display("timeout: %0d cycles passed before the tests finished", cycleLimit);
            $display("sim failed");
            $finish;
        end
    end

    // host tasks start 1 ns after a rising edge and end there too
    task automatic hostWrite(logic [3:0] addr, logic [31:0] data);
        hostAccess.wr = 1'b1;
        hostAccess.addr = addr;
        hostAccess.data = data;
        @(posedge clk);
        #1;
        hostAccess.wr = 1'b0;
    endtask

    task automatic hostRead(logic [3:0] addr, output logic [31:0] data);
        hostAccess.wr = 1'b0;
        hostAccess.addr = addr;
        #1;
        data = regRdata;
        @(posedge clk);
        #1;
    endtask

    task automatic setWindow(int idx, logic [31:0] value);
        hostWrite(extMemPkg::regWindow + 4'(idx), value);
        winModel[idx] = value;
        winKnown[idx] = 1'b1;
    endtask

    task automatic checkWindow();
        logic [31:0] rd;
        for (int i = 0; i < 8; i++) begin
            if (winKnown[i]) begin
                hostRead(extMemPkg::regWindow + 4'(i), rd);
                checkWord($sformatf("window[%0d]", i), rd, winModel[i]);
            end
        end
    endtask

    task automatic startBurst(extMemPkg::busOp op, logic [29:0] addr, int len);
        hostWrite(extMemPkg::regAddr, {2'b00, addr});
        hostWrite(extMemPkg::regLen, 32'(len));
        hostWrite(extMemPkg::regCtrl, 32'(op));
    endtask

    task automatic finishBurst(extMemPkg::busOp op, logic [29:0] addr, int len);
        logic [31:0] st;
        st = 32'd1;
        while (st[0]) begin
            hostRead(extMemPkg::regStatus, st);
        end
        checkStatus(st[0], st[1], 1'b0, 1'b1);
        // status pins must agree with the status register
        checkStatus(busy, done, 1'b0, 1'b1);
        applyBurst(op, addr, len);
        checkWindow();
    endtask

    task automatic runBurst(extMemPkg::busOp op, logic [29:0] addr, int len);
        startBurst(op, addr, len);
        finishBurst(op, addr, len);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] rnd;
        logic [9:0] low;
        logic [29:0] addr;
        int len;
        int risesBefore;
        extMemPkg::busOp op;
        void'($urandom(32'h8d8b));
        hostAccess = '0;
        arstN = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        arstN = 1'b1;

        hostRead(extMemPkg::regStatus, rd);
        checkStatus(rd[0], rd[1], 1'b0, 1'b0);
        checkStatus(busy, done, 1'b0, 1'b0);
        runBurst(extMemPkg::opMmioRead, 30'd0, 1);

        for (int i = 0; i < 8; i++) begin
            setWindow(i, 32'hc0de0000 + 32'(i * 17));
        end
        runBurst(extMemPkg::opWrite, 30'd100, 8);
        for (int i = 0; i < 8; i++) begin
            setWindow(i, 32'd0);
        end
        runBurst(extMemPkg::opMemRead, 30'd100, 8);

        // length is ignored, only window[0] moves
        repeat (3) runBurst(extMemPkg::opMmioRead, 30'd0, 5);

        for (int n = 0; n < randomBursts; n++) begin
            rnd = $urandom;
            op = rnd[31] ? extMemPkg::opMemRead : extMemPkg::opWrite;
            len = $urandom_range(8, 1);
            // near the top of memory or around the first write burst
            low = rnd[0] ? 10'd1016 + 10'(rnd[3:1]) : 10'd96 + 10'(rnd[7:4]);
            addr = {rnd[27:8], low};
            if (op == extMemPkg::opWrite) begin
                for (int i = 0; i < len; i++) begin
                    setWindow(i, $urandom);
                end
            end
            runBurst(op, addr, len);
        end

        for (int i = 0; i < 8; i++) begin
            setWindow(i, 32'h5a5a0000 + 32'(i));
        end
        risesBefore = doneRises;
        startBurst(extMemPkg::opMemRead, 30'd100, 3);
        checkStatus(busy, done, 1'b1, 1'b0);
        hostWrite(extMemPkg::regCtrl, 32'(extMemPkg::opWrite));
        hostWrite(extMemPkg::regAddr, 32'd500);
        hostWrite(extMemPkg::regLen, 32'd8);
        finishBurst(extMemPkg::opMemRead, 30'd100, 3);
        checkWord("done rising edges", 32'(doneRises - risesBefore), 32'd1);
        hostRead(extMemPkg::regCtrl, rd);
        checkWord("ctrl", rd, 32'(extMemPkg::opMemRead));

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+tests
rtl/extMemPkg.sv
rtl/ExternalMemory.sv
rtl/BusMaster.sv
rtl/ControlRegs.sv
rtl/ExtMemSubsystem.sv
tests/tbExtMem.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --timing --assert
TOP = tbExtMem
FILELIST = vlog.f
LOG = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o simv
	./obj_dir/simv > $(LOG) 2>&1; cat $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
